/* rtl/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int LEN_W  = 8;

    // address map
    localparam logic [ADDR_W-1:0] MEM_START_ADDR = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] MEM_END_ADDR   = 32'h0FFF_FFFF;
    localparam logic [ADDR_W-1:0] LED_START_ADDR = 32'h2000_0000;
    localparam logic [ADDR_W-1:0] LED_END_ADDR   = 32'h2FFF_FFFF;

    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = $clog2(MEM_WORDS);  // word index, offset bits 9:2
    localparam int LED_W     = 8;

    typedef enum logic [1:0] {FIXED = 2'b00, INCR = 2'b01} burst_e;
    typedef enum logic [1:0] {OKAY = 2'b00, SLVERR = 2'b10, DECERR = 2'b11} resp_e;
    typedef enum logic [1:0] {SEL_MEM, SEL_LED, SEL_NONE} slave_sel_e;
    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;
    typedef enum logic {RD_IDLE, RD_DATA} rd_state_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;   // beats minus one
        burst_e            burst;
    } axi_aw_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        burst_e            burst;
    } axi_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        resp_e resp;
    } axi_b_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        resp_e             resp;
        logic              last;
    } axi_r_t;

endpackage

`default_nettype wire

/* rtl/axi_bus.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_bus (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire soc_bus_pkg::axi_aw_t   aw,
    input  wire                         aw_valid,
    output logic                        aw_ready,
    input  wire soc_bus_pkg::axi_w_t    w,
    input  wire                         w_valid,
    output logic                        w_ready,
    output soc_bus_pkg::axi_b_t         b,
    output logic                        b_valid,
    input  wire                         b_ready,
    input  wire soc_bus_pkg::axi_ar_t   ar,
    input  wire                         ar_valid,
    output logic                        ar_ready,
    output soc_bus_pkg::axi_r_t         r,
    output logic                        r_valid,
    input  wire                         r_ready,
    output soc_bus_pkg::axi_aw_t        mem_aw,
    output logic                        mem_aw_valid,
    input  wire                         mem_aw_ready,
    output soc_bus_pkg::axi_w_t         mem_w,
    output logic                        mem_w_valid,
    input  wire                         mem_w_ready,
    input  wire soc_bus_pkg::axi_b_t    mem_b,
    input  wire                         mem_b_valid,
    output logic                        mem_b_ready,
    output soc_bus_pkg::axi_ar_t        mem_ar,
    output logic                        mem_ar_valid,
    input  wire                         mem_ar_ready,
    input  wire soc_bus_pkg::axi_r_t    mem_r,
    input  wire                         mem_r_valid,
    output logic                        mem_r_ready,
    output soc_bus_pkg::axi_aw_t        led_aw,
    output logic                        led_aw_valid,
    input  wire                         led_aw_ready,
    output soc_bus_pkg::axi_w_t         led_w,
    output logic                        led_w_valid,
    input  wire                         led_w_ready,
    input  wire soc_bus_pkg::axi_b_t    led_b,
    input  wire                         led_b_valid,
    output logic                        led_b_ready,
    output soc_bus_pkg::axi_ar_t        led_ar,
    output logic                        led_ar_valid,
    input  wire                         led_ar_ready,
    input  wire soc_bus_pkg::axi_r_t    led_r,
    input  wire                         led_r_valid,
    output logic                        led_r_ready
);
    import soc_bus_pkg::*;

    wr_state_e        wr_state;
    rd_state_e        rd_state;
    slave_sel_e       wr_sel, rd_sel;
    slave_sel_e       aw_dec, ar_dec;
    logic [LEN_W-1:0] rd_len;
    logic [LEN_W-1:0] rd_cnt;  // decode-error beat counter

    function automatic slave_sel_e decode(input logic [ADDR_W-1:0] addr);
        if (addr >= MEM_START_ADDR && addr <= MEM_END_ADDR)
            return SEL_MEM;
        if (addr >= LED_START_ADDR && addr <= LED_END_ADDR)
            return SEL_LED;
        return SEL_NONE;  // jtag, spare and unmapped space
    endfunction

    assign aw_dec = decode(aw.addr);
    assign ar_dec = decode(ar.addr);

    assign mem_aw       = aw;
    assign led_aw       = aw;
    assign mem_aw_valid = aw_valid && wr_state == WR_IDLE && aw_dec == SEL_MEM;
    assign led_aw_valid = aw_valid && wr_state == WR_IDLE && aw_dec == SEL_LED;
    assign mem_w        = w;
    assign led_w        = w;
    assign mem_w_valid  = w_valid && wr_state == WR_DATA && wr_sel == SEL_MEM;
    assign led_w_valid  = w_valid && wr_state == WR_DATA && wr_sel == SEL_LED;
    assign mem_b_ready  = b_ready && wr_state == WR_RESP && wr_sel == SEL_MEM;
    assign led_b_ready  = b_ready && wr_state == WR_RESP && wr_sel == SEL_LED;
    assign mem_ar       = ar;
    assign led_ar       = ar;
    assign mem_ar_valid = ar_valid && rd_state == RD_IDLE && ar_dec == SEL_MEM;
    assign led_ar_valid = ar_valid && rd_state == RD_IDLE && ar_dec == SEL_LED;
    assign mem_r_ready  = r_ready && rd_state == RD_DATA && rd_sel == SEL_MEM;
    assign led_r_ready  = r_ready && rd_state == RD_DATA && rd_sel == SEL_LED;

    // write side back to the master
    always_comb begin
        case (aw_dec)
            SEL_MEM: aw_ready = mem_aw_ready;
            SEL_LED: aw_ready = led_aw_ready;
            default: aw_ready = 1'b1;
        endcase
        aw_ready = aw_ready && wr_state == WR_IDLE;
        w_ready  = 1'b1;  // unmapped: swallow data
        b_valid  = 1'b1;
        b        = '{resp: DECERR};
        if (wr_sel == SEL_MEM) begin
            w_ready = mem_w_ready;
            b_valid = mem_b_valid;
            b       = mem_b;
        end else if (wr_sel == SEL_LED) begin
            w_ready = led_w_ready;
            b_valid = led_b_valid;
            b       = led_b;
        end
        w_ready = w_ready && wr_state == WR_DATA;
        b_valid = b_valid && wr_state == WR_RESP;
    end

    always_comb begin
        case (ar_dec)
            SEL_MEM: ar_ready = mem_ar_ready;
            SEL_LED: ar_ready = led_ar_ready;
            default: ar_ready = 1'b1;
        endcase
        ar_ready = ar_ready && rd_state == RD_IDLE;
        r_valid  = 1'b1;
        r        = '{data: '0, resp: DECERR, last: rd_cnt == rd_len};
        if (rd_sel == SEL_MEM) begin
            r_valid = mem_r_valid;
            r       = mem_r;
        end else if (rd_sel == SEL_LED) begin
            r_valid = led_r_valid;
            r       = led_r;
        end
        r_valid = r_valid && rd_state == RD_DATA;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
            wr_sel   <= SEL_NONE;
            rd_state <= RD_IDLE;
            rd_sel   <= SEL_NONE;
            rd_len   <= '0;
            rd_cnt   <= '0;
        end else begin
            case (wr_state)
                WR_IDLE: if (aw_valid && aw_ready) begin
                    wr_sel   <= aw_dec;  // held until b completes
                    wr_state <= WR_DATA;
                end
                WR_DATA: if (w_valid && w_ready && w.last) wr_state <= WR_RESP;
                WR_RESP: if (b_valid && b_ready) wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase
            case (rd_state)
                RD_IDLE: if (ar_valid && ar_ready) begin
                    rd_sel   <= ar_dec;
                    rd_len   <= ar.len;
                    rd_cnt   <= '0;
                    rd_state <= RD_DATA;
                end
                RD_DATA: if (r_valid && r_ready) begin
                    rd_cnt <= rd_cnt + 1'b1;
                    if (r.last) rd_state <= RD_IDLE;
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/mem_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_slave (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire soc_bus_pkg::axi_aw_t   aw,
    input  wire                         aw_valid,
    output logic                        aw_ready,
    input  wire soc_bus_pkg::axi_w_t    w,
    input  wire                         w_valid,
    output logic                        w_ready,
    output soc_bus_pkg::axi_b_t         b,
    output logic                        b_valid,
    input  wire                         b_ready,
    input  wire soc_bus_pkg::axi_ar_t   ar,
    input  wire                         ar_valid,
    output logic                        ar_ready,
    output soc_bus_pkg::axi_r_t         r,
    output logic                        r_valid,
    input  wire                         r_ready,
    output logic                        init_done
);
    import soc_bus_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [MEM_AW-1:0] clr_cnt;
    wr_state_e         wr_state;
    rd_state_e         rd_state;
    logic [ADDR_W-1:0] aw_off, ar_off;
    logic [MEM_AW-1:0] wr_idx, rd_idx, rd_next, rd_addr;
    burst_e            wr_burst, rd_burst;
    logic [LEN_W-1:0]  rd_rem;
    logic [DATA_W-1:0] rd_data;
    logic              aw_fire, w_fire, ar_fire, r_fire;

    assign aw_off   = aw.addr - MEM_START_ADDR;
    assign ar_off   = ar.addr - MEM_START_ADDR;
    assign aw_ready = init_done && wr_state == WR_IDLE;
    assign w_ready  = wr_state == WR_DATA;
    assign b_valid  = wr_state == WR_RESP;
    assign b        = '{resp: OKAY};
    assign ar_ready = init_done && rd_state == RD_IDLE;
    assign r_valid  = rd_state == RD_DATA;
    assign r        = '{data: rd_data, resp: OKAY, last: rd_rem == '0};

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign ar_fire = ar_valid && ar_ready;
    assign r_fire  = r_valid && r_ready;

    assign rd_next = (rd_burst == INCR) ? rd_idx + 1'b1 : rd_idx;  // wraps in the window
    assign rd_addr = ar_fire ? ar_off[MEM_AW+1:2] : rd_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clr_cnt   <= '0;
            init_done <= 1'b0;
            wr_state  <= WR_IDLE;
            rd_state  <= RD_IDLE;
            rd_rem    <= '0;
        end else begin
            if (!init_done) begin
                clr_cnt <= clr_cnt + 1'b1;
                if (clr_cnt == MEM_AW'(MEM_WORDS - 1)) init_done <= 1'b1;
            end
            case (wr_state)
                WR_IDLE: if (aw_fire) wr_state <= WR_DATA;
                WR_DATA: if (w_fire && w.last) wr_state <= WR_RESP;
                WR_RESP: if (b_valid && b_ready) wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase
            case (rd_state)
                RD_IDLE: if (ar_fire) begin
                    rd_rem   <= ar.len;
                    rd_state <= RD_DATA;
                end
                RD_DATA: if (r_fire) begin
                    rd_rem <= rd_rem - 1'b1;
                    if (r.last) rd_state <= RD_IDLE;
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // clear sweep first, then byte-masked writes
    always_ff @(posedge clk) begin
        if (!init_done)
            mem[clr_cnt] <= '0;
        else if (w_fire)
            for (int i = 0; i < STRB_W; i++)
                if (w.strb[i]) mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_idx   <= aw_off[MEM_AW+1:2];
            wr_burst <= aw.burst;
        end else if (w_fire && wr_burst == INCR) begin
            wr_idx <= wr_idx + 1'b1;
        end
        if (ar_fire) begin
            rd_idx   <= ar_off[MEM_AW+1:2];
            rd_burst <= ar.burst;
        end else if (r_fire) begin
            rd_idx <= rd_next;
        end
        if (ar_fire || (r_fire && !r.last))
            rd_data <= mem[rd_addr];  // holds while rready is low
    end

endmodule

`default_nettype wire

/* rtl/led_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module led_slave (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire soc_bus_pkg::axi_aw_t   aw,
    input  wire                         aw_valid,
    output logic                        aw_ready,
    input  wire soc_bus_pkg::axi_w_t    w,
    input  wire                         w_valid,
    output logic                        w_ready,
    output soc_bus_pkg::axi_b_t         b,
    output logic                        b_valid,
    input  wire                         b_ready,
    input  wire soc_bus_pkg::axi_ar_t   ar,
    input  wire                         ar_valid,
    output logic                        ar_ready,
    output soc_bus_pkg::axi_r_t         r,
    output logic                        r_valid,
    input  wire                         r_ready,
    output logic [soc_bus_pkg::DATA_W-1:0] led_reg
);
    import soc_bus_pkg::*;

    wr_state_e         wr_state;
    rd_state_e         rd_state;
    logic [LEN_W-1:0]  rd_rem;
    logic [DATA_W-1:0] rd_data;

    // one register for the whole window, so aw carries nothing needed here
    assign aw_ready = wr_state == WR_IDLE;
    assign w_ready  = wr_state == WR_DATA;
    assign b_valid  = wr_state == WR_RESP;
    assign b        = '{resp: OKAY};
    assign ar_ready = rd_state == RD_IDLE;
    assign r_valid  = rd_state == RD_DATA;
    assign r        = '{data: rd_data, resp: OKAY, last: rd_rem == '0};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led_reg  <= '0;
            wr_state <= WR_IDLE;
            rd_state <= RD_IDLE;
            rd_rem   <= '0;
        end else begin
            case (wr_state)
                WR_IDLE: if (aw_valid && aw_ready) wr_state <= WR_DATA;
                WR_DATA: if (w_valid) begin
                    for (int i = 0; i < STRB_W; i++)
                        if (w.strb[i]) led_reg[8*i +: 8] <= w.data[8*i +: 8];
                    if (w.last) wr_state <= WR_RESP;
                end
                WR_RESP: if (b_ready) wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase
            case (rd_state)
                RD_IDLE: if (ar_valid) begin
                    rd_rem   <= ar.len;
                    rd_state <= RD_DATA;
                end
                RD_DATA: if (r_ready) begin
                    rd_rem <= rd_rem - 1'b1;
                    if (r.last) rd_state <= RD_IDLE;
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // snapshot per beat so a stalled beat keeps its data
    always_ff @(posedge clk) begin
        if ((ar_valid && ar_ready) || (r_valid && r_ready))
            rd_data <= led_reg;
    end

endmodule

`default_nettype wire

/* rtl/soc_top.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire soc_bus_pkg::axi_aw_t   aw,
    input  wire                         aw_valid,
    output logic                        aw_ready,
    input  wire soc_bus_pkg::axi_w_t    w,
    input  wire                         w_valid,
    output logic                        w_ready,
    output soc_bus_pkg::axi_b_t         b,
    output logic                        b_valid,
    input  wire                         b_ready,
    input  wire soc_bus_pkg::axi_ar_t   ar,
    input  wire                         ar_valid,
    output logic                        ar_ready,
    output soc_bus_pkg::axi_r_t         r,
    output logic                        r_valid,
    input  wire                         r_ready,
    output logic [soc_bus_pkg::LED_W-1:0] led
);
    import soc_bus_pkg::*;

    axi_aw_t           mem_aw, led_aw;
    axi_w_t            mem_w, led_w;
    axi_b_t            mem_b, led_b;
    axi_ar_t           mem_ar, led_ar;
    axi_r_t            mem_r, led_r;
    logic              mem_aw_valid, mem_aw_ready, led_aw_valid, led_aw_ready;
    logic              mem_w_valid, mem_w_ready, led_w_valid, led_w_ready;
    logic              mem_b_valid, mem_b_ready, led_b_valid, led_b_ready;
    logic              mem_ar_valid, mem_ar_ready, led_ar_valid, led_ar_ready;
    logic              mem_r_valid, mem_r_ready, led_r_valid, led_r_ready;
    logic              init_done;
    logic [DATA_W-1:0] led_reg;

    axi_bus u_bus (.*);

    mem_slave u_mem (
        .clk, .rst_n,
        .aw(mem_aw), .aw_valid(mem_aw_valid), .aw_ready(mem_aw_ready),
        .w(mem_w), .w_valid(mem_w_valid), .w_ready(mem_w_ready),
        .b(mem_b), .b_valid(mem_b_valid), .b_ready(mem_b_ready),
        .ar(mem_ar), .ar_valid(mem_ar_valid), .ar_ready(mem_ar_ready),
        .r(mem_r), .r_valid(mem_r_valid), .r_ready(mem_r_ready),
        .init_done
    );

    led_slave u_led (
        .clk, .rst_n,
        .aw(led_aw), .aw_valid(led_aw_valid), .aw_ready(led_aw_ready),
        .w(led_w), .w_valid(led_w_valid), .w_ready(led_w_ready),
        .b(led_b), .b_valid(led_b_valid), .b_ready(led_b_ready),
        .ar(led_ar), .ar_valid(led_ar_valid), .ar_ready(led_ar_ready),
        .r(led_r), .r_valid(led_r_valid), .r_ready(led_r_ready),
        .led_reg
    );

    assign led = {init_done, led_reg[LED_W-2:0]};  // init done on the top pin

endmodule

`default_nettype wire

/* tb/tb_soc_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_soc_top;
    import soc_bus_pkg::*;

    logic              clk = 1'b0;
    logic              rst_n;
    axi_aw_t           aw;
    logic              aw_valid, aw_ready;
    axi_w_t            w;
    logic              w_valid, w_ready;
    axi_b_t            b;
    logic              b_valid, b_ready;
    axi_ar_t           ar;
    logic              ar_valid, ar_ready;
    axi_r_t            r;
    logic              r_valid, r_ready;
    logic [LED_W-1:0]  led;

    logic [31:0]       lfsr = 32'hc9d3;
    int                errors = 0;
    int                checks = 0;
    logic [DATA_W-1:0] wdata [MEM_WORDS];
    logic [STRB_W-1:0] wstrb [MEM_WORDS];
    logic [DATA_W-1:0] ref_mem [MEM_WORDS];  // expected memory contents
    logic [DATA_W-1:0] ref_led;

    soc_top uut (.*);

    initial begin
        forever #50 clk = ~clk;
    end

    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32 22 2 1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    function automatic slave_sel_e target_of(input logic [ADDR_W-1:0] addr);
        case (addr[31:28])  // 256 MB windows
            4'h0: return SEL_MEM;
            4'h2: return SEL_LED;
            default: return SEL_NONE;
        endcase
    endfunction

    function automatic int word_of(input logic [ADDR_W-1:0] addr);
        return int'((addr - MEM_START_ADDR) >> 2) % MEM_WORDS;
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic fill_random(input int len);
        for (int i = 0; i <= len; i++) begin
            wdata[i] = rand_bits(32);
            wstrb[i] = '1;
        end
    endtask

    task automatic write_burst(input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len,
                               input burst_e burst, input bit bp);
        slave_sel_e tgt;
        int         idx, stall;
        bit         seen, done;
        resp_e      first_resp;
        tgt = target_of(addr);
        idx = word_of(addr);
        @(negedge clk);
        aw       = '{addr: addr, len: len, burst: burst};
        aw_valid = 1'b1;
        #25;
        while (!aw_ready) begin
            @(negedge clk);
            #25;
        end
        @(negedge clk);
        aw_valid = 1'b0;
        for (int i = 0; i <= len; i++) begin
            w       = '{data: wdata[i], strb: wstrb[i], last: i == len};
            w_valid = 1'b1;
            #25;
            while (!w_ready) begin
                @(negedge clk);
                #25;
            end
            @(negedge clk);
        end
        w_valid = 1'b0;
        stall   = bp ? int'(rand_bits(3)) : 0;
        seen    = 1'b0;
        done    = 1'b0;
        b_ready = !bp;
        while (!done) begin
            #25;
            if (b_valid) begin
                if (!seen)
                    first_resp = b.resp;
                check(b.resp, first_resp, "b payload under back-pressure");
                seen = 1'b1;
                done = b_ready;
            end else if (seen) begin
                $display("b_valid dropped before it was accepted at %0t", $time);
                errors++;
            end
            @(negedge clk);
            if (seen && stall > 0)
                stall--;
            b_ready = seen ? stall == 0 : !bp;
        end
        b_ready = 1'b0;
        check(first_resp, tgt == SEL_NONE ? DECERR : OKAY, "bresp");
        for (int i = 0; i <= len; i++) begin
            for (int j = 0; j < STRB_W; j++) begin
                if (wstrb[i][j] && tgt == SEL_MEM)
                    ref_mem[idx][8*j +: 8] = wdata[i][8*j +: 8];
                if (wstrb[i][j] && tgt == SEL_LED)
                    ref_led[8*j +: 8] = wdata[i][8*j +: 8];
            end
            if (burst == INCR)
                idx = (idx + 1) % MEM_WORDS;
        end
    endtask

    task automatic read_burst(input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len,
                              input burst_e burst, input bit bp);
        slave_sel_e        tgt;
        int                idx, beat;
        bit                held;
        axi_r_t            held_r;
        logic [DATA_W-1:0] exp_data;
        tgt = target_of(addr);
        idx = word_of(addr);
        @(negedge clk);
        ar       = '{addr: addr, len: len, burst: burst};
        ar_valid = 1'b1;
        #25;
        while (!ar_ready) begin
            @(negedge clk);
            #25;
        end
        @(negedge clk);
        ar_valid = 1'b0;
        beat     = 0;
        held     = 1'b0;
        r_ready  = bp ? lfsr_step() : 1'b1;
        while (beat <= len) begin
            #25;
            if (r_valid) begin
                if (held)
                    check(r, held_r, "r payload under back-pressure");
                held   = !r_ready;
                held_r = r;
                if (r_ready) begin
                    case (tgt)
                        SEL_MEM: exp_data = ref_mem[idx];
                        SEL_LED: exp_data = ref_led;
                        default: exp_data = '0;
                    endcase
                    check(r.data, exp_data, "rdata");
                    check(r.resp, tgt == SEL_NONE ? DECERR : OKAY, "rresp");
                    check(r.last, beat == len, "rlast");
                    beat++;
                    if (burst == INCR)
                        idx = (idx + 1) % MEM_WORDS;
                end
            end else if (held) begin
                $display("r_valid dropped before the beat was accepted at %0t", $time);
                errors++;
                held = 1'b0;
            end
            @(negedge clk);
            r_ready = bp ? lfsr_step() : 1'b1;
        end
        r_ready = 1'b0;
        #25;
        check(r_valid, 1'b0, "no r beat after rlast");
    endtask

    task automatic reset_and_init();
        int cycles;
        #25;
        check(b_valid, 1'b0, "b_valid after reset");
        check(r_valid, 1'b0, "r_valid after reset");
        check(led, '0, "led after reset");
        check(aw_ready, 1'b0, "aw_ready while memory clears");
        check(ar_ready, 1'b0, "ar_ready while memory clears");
        cycles = 0;
        while (!led[7] && cycles < 2 * MEM_WORDS) begin
            @(negedge clk);
            cycles++;
        end
        if (!led[7]) begin
            $display("init done never came up after reset");
            errors++;
        end else begin
            check(cycles, MEM_WORDS, "clear sweep length");
            check(aw_ready, 1'b1, "aw_ready after init done");
            check(ar_ready, 1'b1, "ar_ready after init done");
        end
        read_burst(32'h0000_0040, 8'd7, INCR, 1'b0);
    endtask

    task automatic mem_round_trip();
        fill_random(7);
        write_burst(32'h0000_0100, 8'd7, INCR, 1'b0);
        read_burst(32'h0000_0100, 8'd7, INCR, 1'b0);
    endtask

    task automatic strobe_fixed_wrap();
        wdata[0] = 32'h1122_3344;
        wstrb[0] = 4'hf;
        write_burst(32'h0000_0200, 8'd0, INCR, 1'b0);
        wdata[0] = 32'haabb_ccdd;
        wstrb[0] = 4'b0101;
        write_burst(32'h0000_0200, 8'd0, INCR, 1'b0);
        read_burst(32'h0000_0200, 8'd0, INCR, 1'b0);
        fill_random(3);
        write_burst(32'h0000_0300, 8'd3, FIXED, 1'b0);
        read_burst(32'h0000_02fc, 8'd2, INCR, 1'b0);  // neighbours untouched
        fill_random(3);
        write_burst(32'h0000_03f8, 8'd3, INCR, 1'b0);  // words 254, 255, 0, 1
        read_burst(32'h0000_03f8, 8'd3, INCR, 1'b0);
        read_burst(32'h0000_0000, 8'd1, INCR, 1'b0);
    endtask

    task automatic led_access();
        fill_random(0);
        write_burst(LED_START_ADDR + 32'h10, 8'd0, INCR, 1'b0);
        check(led, {1'b1, ref_led[6:0]}, "led pins after write");
        wdata[0] = rand_bits(32);
        wstrb[0] = 4'b0010;  // byte 1 only, pins unchanged
        write_burst(LED_START_ADDR + 32'h0123_4560, 8'd0, INCR, 1'b0);
        check(led, {1'b1, ref_led[6:0]}, "led pins after masked write");
        read_burst(LED_END_ADDR - 32'h3, 8'd2, INCR, 1'b0);
        read_burst(LED_START_ADDR, 8'd0, FIXED, 1'b0);
    endtask

    task automatic decode_error();
        fill_random(2);
        write_burst(32'h1000_0040, 8'd2, INCR, 1'b0);  // between ddr and led windows
        write_burst(32'h3000_0000, 8'd0, INCR, 1'b0);
        read_burst(32'h1000_0040, 8'd4, INCR, 1'b0);
        read_burst(32'hf000_0000, 8'd0, INCR, 1'b0);
        read_burst(32'h0000_0000, 8'd18, INCR, 1'b0);  // words the offsets above alias to
        read_burst(LED_START_ADDR, 8'd0, INCR, 1'b0);
        check(led, {1'b1, ref_led[6:0]}, "led pins after decode errors");
    endtask

    task automatic back_pressure();
        fill_random(7);
        write_burst(32'h0000_0180, 8'd7, INCR, 1'b1);
        read_burst(32'h0000_0180, 8'd7, INCR, 1'b1);
        read_burst(32'h0000_0100, 8'd7, INCR, 1'b1);
        read_burst(32'h1000_0000, 8'd3, INCR, 1'b1);
    endtask

    initial begin
        rst_n    = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        ref_led  = '0;
        for (int i = 0; i < MEM_WORDS; i++)
            ref_mem[i] = '0;  // cleared by the memory after reset
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        reset_and_init();
        mem_round_trip();
        strobe_fixed_wrap();
        led_access();
        decode_error();
        back_pressure();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // reset, clear sweep and about 30 bursts of at most 40 cycles, doubled
    initial begin
        #(100 * 2 * (5 + MEM_WORDS + 30 * 40));
        $display("timeout: the tests did not complete in the expected time");
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
rtl/soc_bus_pkg.sv
rtl/axi_bus.sv
rtl/mem_slave.sv
rtl/led_slave.sv
rtl/soc_top.sv
tb/tb_soc_top.sv
